// File: verilog/gemac_pkg.sv
package gemac_pkg;

   typedef logic [7:0]  byte_t;          // gmii or client byte
   typedef logic [47:0] mac_addr_t;
   typedef logic [15:0] pause_quanta_t;  // units of 512 bit times
   typedef logic [31:0] fcs_t;
   typedef logic [15:0] frame_len_t;     // bytes since preamble start
   typedef logic [4:0]  pause_idx_t;

   // preamble start to last data or pad byte, 8 + 60
   localparam frame_len_t min_frame_len = 16'd68;
   localparam int pause_hdr_len = 18;    // da, sa, type, opcode, time

   localparam mac_addr_t flow_ctrl_addr = 48'h01_80_c2_00_00_01;
   localparam logic [15:0] mac_ctrl_type = 16'h8808;
   localparam logic [15:0] pause_opcode = 16'h0001;

   typedef enum logic [3:0] {
      idle,
      preamble,
      sfd,
      first_byte,   // client byte on tx_data, tx_ack high
      in_frame,
      in_frame_2,   // past minimum length, no padding needed
      pad,
      fcs,
      underrun,
      pause_pre,
      pause_sfd,
      pause_hdr
   } tx_state_e;

endpackage

// File: verilog/gemac_ifs.sv
// crc accumulator controls and result
interface crc_if;
   import gemac_pkg::*;

   logic  clear;   // restart at all ones
   logic  calc;    // fold data this cycle
   byte_t data;
   fcs_t  fcs;     // 31:24 goes out first

   modport tx (output clear, calc, data, input fcs);
   modport crc (input clear, calc, data, output fcs);

endinterface

// pause frame request and header byte lookup
interface pause_if;
   import gemac_pkg::*;

   logic       pending;   // pause frame owed
   logic       start;     // pause_pre entered
   pause_idx_t idx;
   byte_t      dat;       // header byte for idx

   modport tx (input pending, dat, output start, idx);
   modport src (output pending, dat, input start, idx);

endinterface

// File: verilog/eth_crc32.sv
module eth_crc32 (
   input logic tx_clk,
   input logic reset,
   crc_if.crc  crc
);
   import gemac_pkg::*;

   localparam fcs_t crc_poly = 32'hedb8_8320;  // 0x04c11db7 bit reversed

   fcs_t crc_reg;
   fcs_t crc_next;

   // lsb first, one bit per iteration
   always_comb
   begin
      crc_next = crc_reg;
      for (int i = 0; i < 8; i++)
      begin
         if (crc_next[0] ^ crc.data[i])
            crc_next = (crc_next >> 1) ^ crc_poly;
         else
            crc_next = crc_next >> 1;
      end
   end

   always_ff @(posedge tx_clk)
   begin
      if (reset || crc.clear)
         crc_reg <= '1;
      else if (crc.calc)
         crc_reg <= crc_next;
   end

   // complement, low byte of the register leads on the wire
   assign crc.fcs = ~{crc_reg[7:0], crc_reg[15:8], crc_reg[23:16], crc_reg[31:24]};

endmodule

// File: verilog/pause_frame_src.sv
module pause_frame_src (
   input  logic                     tx_clk,
   input  logic                     reset,
   input  logic                     pause_req,
   input  gemac_pkg::pause_quanta_t pause_time,
   input  gemac_pkg::mac_addr_t     mac_addr,
   pause_if.src                     pause
);
   import gemac_pkg::*;

   logic          pending_q;
   pause_quanta_t time_held;
   byte_t         hdr_byte;

   // whole header, first byte on the wire in the top bits
   logic [8*pause_hdr_len-1:0] hdr;

   // a new request wins over start in the same cycle
   always_ff @(posedge tx_clk)
   begin
      if (reset)
         pending_q <= 1'b0;
      else if (pause_req)
         pending_q <= 1'b1;
      else if (pause.start)
         pending_q <= 1'b0;
   end

   always_ff @(posedge tx_clk)
   begin
      if (pause_req)
         time_held <= pause_time;   // later request overwrites
   end

   assign hdr = {flow_ctrl_addr,
                 mac_addr,
                 mac_ctrl_type,
                 pause_opcode,
                 time_held};

   always_comb
   begin
      if (int'(pause.idx) < pause_hdr_len)
         hdr_byte = hdr[8*(pause_hdr_len-1-int'(pause.idx)) +: 8];
      else
         hdr_byte = '0;
   end

   assign pause.dat     = hdr_byte;
   assign pause.pending = pending_q;

endmodule

// File: verilog/gemac_tx.sv
module gemac_tx #(
   parameter int startup_gap = 100
) (
   input  logic             tx_clk,
   input  logic             reset,
   input  gemac_pkg::byte_t tx_data,
   input  logic             tx_valid,
   input  logic             tx_error,
   output logic             tx_ack,
   input  gemac_pkg::byte_t ifg,
   crc_if.tx                crc,
   pause_if.tx              pause,
   output logic             gmii_tx_en,
   output logic             gmii_tx_er,
   output gemac_pkg::byte_t gmii_txd
);
   import gemac_pkg::*;

   localparam frame_len_t hdr_start = 16'd8;       // preamble plus sfd
   localparam frame_len_t hdr_last = hdr_start + frame_len_t'(pause_hdr_len) - 16'd1;
   localparam logic [2:0] preamble_last = 3'd6;    // seven 0x55 bytes
   localparam logic [2:0] fcs_last = 3'd3;

   tx_state_e  state;
   tx_state_e  state_next;
   logic [2:0] step;         // position inside preamble and fcs
   frame_len_t frame_len;
   byte_t      gap_cnt;
   logic       gap_done;
   logic       fcs_done;

   logic  tx_en_pre;
   logic  tx_er_pre;
   byte_t txd_pre;
   byte_t fcs_byte;

   assign gap_done = (gap_cnt == '0);
   assign fcs_done = (state == fcs) && (step == fcs_last);

   // pause frames go ahead of client data
   always_comb
   begin
      state_next = state;
      case (state)
         idle:
            if (gap_done)
            begin
               if (pause.pending)
                  state_next = pause_pre;
               else if (tx_valid)
                  state_next = preamble;
            end
         preamble:
            if (step == preamble_last)
               state_next = sfd;
         pause_pre:
            if (step == preamble_last)
               state_next = pause_sfd;
         sfd:
            state_next = first_byte;
         pause_sfd:
            state_next = pause_hdr;
         first_byte:
            if (tx_error)
               state_next = underrun;
            else if (!tx_valid)
               state_next = pad;
            else
               state_next = in_frame;
         in_frame:
            if (tx_error)
               state_next = underrun;
            else if (!tx_valid)
               state_next = pad;
            else if (frame_len == min_frame_len - 16'd1)
               state_next = in_frame_2;
         in_frame_2:
            if (tx_error)
               state_next = underrun;
            else if (!tx_valid)
               state_next = fcs;
         pad:
            if (frame_len == min_frame_len)
               state_next = fcs;
         pause_hdr:
            if (frame_len == hdr_last)
               state_next = pad;
         fcs:
            if (step == fcs_last)
               state_next = idle;
         underrun:
            state_next = idle;
         default:
            state_next = idle;
      endcase
   end

   always_ff @(posedge tx_clk)
   begin
      if (reset)
      begin
         state <= idle;
         step  <= '0;
      end
      else
      begin
         state <= state_next;
         step  <= (state_next == state) ? step + 3'd1 : 3'd0;  // restart on each new state
      end
   end

   always_ff @(posedge tx_clk)
   begin
      if (reset || state == idle)
         frame_len <= '0;
      else
         frame_len <= frame_len + 16'd1;
   end

   // no reload after an underrun
   always_ff @(posedge tx_clk)
   begin
      if (reset)
         gap_cnt <= byte_t'(startup_gap);
      else if (fcs_done)
         gap_cnt <= ifg;
      else if (!gap_done)
         gap_cnt <= gap_cnt - 8'd1;
   end

   // first output stage
   always_ff @(posedge tx_clk)
   begin
      if (reset)
      begin
         tx_en_pre <= 1'b0;
         tx_er_pre <= 1'b0;
         txd_pre   <= '0;
      end
      else
      begin
         case (state)
            idle:
            begin
               tx_en_pre <= 1'b0;
               tx_er_pre <= 1'b0;
               txd_pre   <= '0;
            end
            preamble, pause_pre:
            begin
               tx_en_pre <= 1'b1;
               txd_pre   <= 8'h55;
            end
            sfd, pause_sfd:
               txd_pre <= 8'hd5;
            first_byte, in_frame, in_frame_2:
               txd_pre <= tx_valid ? tx_data : 8'h00;
            pad:
               txd_pre <= '0;
            pause_hdr:
               txd_pre <= pause.dat;
            underrun:
            begin
               tx_er_pre <= 1'b1;
               txd_pre   <= '0;
            end
            fcs:
               if (fcs_done)
                  tx_en_pre <= 1'b0;   // en drops after the last fcs byte
            default:
               txd_pre <= '0;
         endcase
      end
   end

   always_comb
   begin
      case (step[1:0])
         2'd0:    fcs_byte = crc.fcs[31:24];
         2'd1:    fcs_byte = crc.fcs[23:16];
         2'd2:    fcs_byte = crc.fcs[15:8];
         default: fcs_byte = crc.fcs[7:0];
      endcase
   end

   // second stage, fcs replaces the pre-stage byte
   always_ff @(posedge tx_clk)
   begin
      if (reset)
      begin
         gmii_tx_en <= 1'b0;
         gmii_tx_er <= 1'b0;
         gmii_txd   <= '0;
      end
      else
      begin
         gmii_tx_en <= tx_en_pre;
         gmii_tx_er <= tx_er_pre;
         gmii_txd   <= (state == fcs) ? fcs_byte : txd_pre;
      end
   end

   assign crc.clear = (state == idle);
   assign crc.data  = txd_pre;
   // sfd still sits in txd_pre on the first header cycle
   assign crc.calc  = (state == in_frame) || (state == in_frame_2) || (state == pad) ||
                      ((state == pause_hdr) && (frame_len != hdr_start));

   assign pause.start = (state == idle) && gap_done && pause.pending;
   assign pause.idx   = pause_idx_t'(frame_len[4:0] - hdr_start[4:0]);

   assign tx_ack = (state == first_byte);

endmodule

// File: verilog/gemac_tx_top.sv
module gemac_tx_top #(
   parameter int startup_gap = 100   // gap timer value out of reset
) (
   input  logic                     tx_clk,
   input  logic                     reset,
   output logic                     gmii_tx_en,
   output logic                     gmii_tx_er,
   output gemac_pkg::byte_t         gmii_txd,
   input  gemac_pkg::byte_t         tx_data,
   input  logic                     tx_valid,
   input  logic                     tx_error,
   output logic                     tx_ack,
   input  gemac_pkg::byte_t         ifg,
   input  gemac_pkg::mac_addr_t     mac_addr,
   input  logic                     pause_req,
   input  gemac_pkg::pause_quanta_t pause_time
);

   crc_if   crc_bus ();
   pause_if pause_bus ();

   gemac_tx #(
      .startup_gap (startup_gap)
   ) gemac_tx_inst (
      .tx_clk     (tx_clk),
      .reset      (reset),
      .tx_data    (tx_data),
      .tx_valid   (tx_valid),
      .tx_error   (tx_error),
      .tx_ack     (tx_ack),
      .ifg        (ifg),
      .crc        (crc_bus.tx),
      .pause      (pause_bus.tx),
      .gmii_tx_en (gmii_tx_en),
      .gmii_tx_er (gmii_tx_er),
      .gmii_txd   (gmii_txd)
   );

   eth_crc32 eth_crc32_inst (
      .tx_clk (tx_clk),
      .reset  (reset),
      .crc    (crc_bus.crc)
   );

   pause_frame_src pause_frame_src_inst (
      .tx_clk     (tx_clk),
      .reset      (reset),
      .pause_req  (pause_req),
      .pause_time (pause_time),
      .mac_addr   (mac_addr),
      .pause      (pause_bus.src)
   );

endmodule

// File: verif/tb_clock.sv
module tb_clock (
   output logic tx_clk,
   output logic reset
);
   timeunit 1ns;
   timeprecision 1ps;

   localparam int half_period = 10;   // 20 ns clock
   localparam int reset_cycles = 8;

   initial
   begin
      tx_clk = 1'b0;
      forever
         #half_period tx_clk = ~tx_clk;
   end

   // released on a falling edge like the rest of the stimulus
   initial
   begin
      reset = 1'b1;
      repeat (reset_cycles) @(posedge tx_clk);
      @(negedge tx_clk);
      reset = 1'b0;
   end

endmodule

// File: verif/gemac_tx_assert.sv
module gemac_tx_assert (
   input logic tx_clk,
   input logic reset,
   input logic gmii_tx_en,
   input logic gmii_tx_er,
   input logic tx_ack
);
   timeunit 1ns;
   timeprecision 1ps;

   int fail_count = 0;   // failed assertions so far

   property er_inside_frame;
      @(posedge tx_clk) disable iff (reset) gmii_tx_er |-> gmii_tx_en;
   endproperty

   property ack_one_cycle;
      @(posedge tx_clk) disable iff (reset) tx_ack |=> !tx_ack;
   endproperty

   // sync reset, so checked one edge later
   property quiet_in_reset;
      @(posedge tx_clk) reset |=> !gmii_tx_en;
   endproperty

   er_in_frame_chk: assert property (er_inside_frame)
      else
      begin
         $error("gmii_tx_er high while gmii_tx_en is low");
         fail_count = fail_count + 1;
      end
   ack_pulse_chk: assert property (ack_one_cycle)
      else
      begin
         $error("tx_ack high for two cycles in a row");
         fail_count = fail_count + 1;
      end
   reset_quiet_chk: assert property (quiet_in_reset)
      else
      begin
         $error("gmii_tx_en high during reset");
         fail_count = fail_count + 1;
      end

endmodule

// File: verif/gemac_tx_tb.sv
module gemac_tx_tb;
   timeunit 1ns;
   timeprecision 1ps;
   import gemac_pkg::*;

   localparam int ifg_cycles = 12;
   localparam int startup_cycles = 100;   // gap timer out of reset
   localparam int frame_count = 8;
   // wire bytes of every frame the tests send
   localparam int wire_bytes = 72 + 112 + 20 + 76 + 72 + 72 + 72 + 72;
   localparam int watchdog_ns = (wire_bytes + startup_cycles + frame_count * ifg_cycles) * 40;
   localparam int wait_limit = 400;       // cycles for one handshake

   logic          tx_clk;
   logic          reset;
   logic          gmii_tx_en;
   logic          gmii_tx_er;
   byte_t         gmii_txd;
   byte_t         tx_data;
   logic          tx_valid;
   logic          tx_error;
   logic          tx_ack;
   byte_t         ifg;
   mac_addr_t     mac_addr;
   logic          pause_req;
   pause_quanta_t pause_time;

   logic [31:0] rng_state = 32'd21108;
   byte_t body_q[$];       // payload or pause header
   byte_t exp_q[$];        // expected bytes on the wire
   byte_t log_q[$];        // every byte seen with gmii_tx_en
   int    frame_base[$];   // first byte of each frame in log_q
   int    frame_size[$];
   int    frame_gap[$];    // idle cycles before the frame
   int    frame_er[$];
   int    er_pos[$];
   int    ack_total = 0;
   int    idle_run = 0;
   int    cur_size;
   int    cur_er;
   int    cur_er_pos;
   logic  en_last = 1'b0;

   tb_clock tb_clock_inst (
      .tx_clk (tx_clk),
      .reset  (reset)
   );

   gemac_tx_top #(
      .startup_gap (startup_cycles)
   ) gemac_tx_top_inst (
      .tx_clk     (tx_clk),
      .reset      (reset),
      .gmii_tx_en (gmii_tx_en),
      .gmii_tx_er (gmii_tx_er),
      .gmii_txd   (gmii_txd),
      .tx_data    (tx_data),
      .tx_valid   (tx_valid),
      .tx_error   (tx_error),
      .tx_ack     (tx_ack),
      .ifg        (ifg),
      .mac_addr   (mac_addr),
      .pause_req  (pause_req),
      .pause_time (pause_time)
   );

   bind gemac_tx gemac_tx_assert gemac_tx_assert_inst (
      .tx_clk     (tx_clk),
      .reset      (reset),
      .gmii_tx_en (gmii_tx_en),
      .gmii_tx_er (gmii_tx_er),
      .tx_ack     (tx_ack)
   );

   // gmii collector on the falling edge
   always @(negedge tx_clk)
   begin
      if (tx_ack === 1'b1)
         ack_total++;
      if (gmii_tx_en === 1'b1)
      begin
         if (!en_last)
         begin
            frame_base.push_back(log_q.size());
            frame_gap.push_back(idle_run);
            cur_size   = 0;
            cur_er     = 0;
            cur_er_pos = -1;
         end
         if (gmii_tx_er === 1'b1)
         begin
            cur_er++;
            cur_er_pos = cur_size;
         end
         log_q.push_back(gmii_txd);
         cur_size++;
         idle_run = 0;
      end
      else
      begin
         if (en_last)
         begin
            frame_size.push_back(cur_size);
            frame_er.push_back(cur_er);
            er_pos.push_back(cur_er_pos);
         end
         idle_run++;
      end
      en_last = (gmii_tx_en === 1'b1);
   end

   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("SOME TESTS FAILED");
      $fatal(1);
   endtask

   task automatic check_value(input string what, input logic [63:0] got,
                              input logic [63:0] expected);
      if (got !== expected)
         fail_run($sformatf("ERR at %0t: %s is %0h, expected %0h", $time, what, got, expected));
   endtask

   function automatic logic [31:0] xorshift32();
      rng_state ^= rng_state << 13;
      rng_state ^= rng_state >> 17;
      rng_state ^= rng_state << 5;
      return rng_state;
   endfunction

   task automatic fill_payload(input int len);
      logic [31:0] r;
      body_q.delete();
      for (int i = 0; i < len; i++)
      begin
         r = xorshift32();
         body_q.push_back(r[7:0]);
      end
   endtask

   // da, sa, type, opcode, time, high byte first
   task automatic load_pause_body(input mac_addr_t addr, input pause_quanta_t quanta);
      body_q = '{8'h01, 8'h80, 8'hc2, 8'h00, 8'h00, 8'h01};
      for (int i = 5; i >= 0; i--)
         body_q.push_back(addr[8*i +: 8]);
      body_q.push_back(8'h88);
      body_q.push_back(8'h08);
      body_q.push_back(8'h00);
      body_q.push_back(8'h01);
      body_q.push_back(quanta[15:8]);
      body_q.push_back(quanta[7:0]);
   endtask

   // msb first shift register on the byte bits lsb first, reversed at the end
   function automatic logic [31:0] ref_fcs(input int from);
      logic [31:0] crc;
      logic [31:0] rev;
      byte_t       d;
      logic        fb;
      crc = '1;
      for (int n = from; n < exp_q.size(); n++)
      begin
         d = exp_q[n];
         for (int b = 0; b < 8; b++)
         begin
            fb  = crc[31] ^ d[b];
            crc = crc << 1;
            if (fb)
               crc = crc ^ 32'h04c1_1db7;
         end
      end
      for (int b = 0; b < 32; b++)
         rev[b] = crc[31-b];
      return ~rev;
   endfunction

   task automatic make_expected();
      logic [31:0] fcs_val;
      exp_q.delete();
      repeat (7) exp_q.push_back(8'h55);
      exp_q.push_back(8'hd5);
      foreach (body_q[i])
         exp_q.push_back(body_q[i]);
      while (exp_q.size() < 68)
         exp_q.push_back(8'h00);   // pad to 60 bytes after the sfd
      fcs_val = ref_fcs(8);
      for (int i = 0; i < 4; i++)
         exp_q.push_back(fcs_val[8*i +: 8]);   // low byte first
   endtask

   task automatic compare_bytes(input int idx, input int count);
      for (int i = 0; i < count; i++)
         check_value($sformatf("frame %0d byte %0d", idx, i),
                     log_q[frame_base[idx] + i], exp_q[i]);
   endtask

   task automatic verify_frame(input int idx);
      check_value($sformatf("frame %0d length", idx), frame_size[idx], exp_q.size());
      check_value($sformatf("frame %0d tx_er cycles", idx), frame_er[idx], 0);
      compare_bytes(idx, exp_q.size());
   endtask

   task automatic wait_frames(input int n);
      int waited;
      waited = 0;
      while (frame_size.size() < n)
      begin
         @(posedge tx_clk);
         waited++;
         if (waited > wait_limit)
            fail_run("timed out waiting for a frame to end on GMII");
      end
   endtask

   // first byte held until tx_ack then one byte per cycle
   task automatic send_payload(input int err_at, input logic with_pause);
      int waited;
      waited = 0;
      @(negedge tx_clk);
      tx_data   = body_q[0];
      tx_valid  = 1'b1;
      pause_req = with_pause;   // same edge as tx_valid
      while (tx_ack !== 1'b1)
      begin
         @(negedge tx_clk);
         pause_req = 1'b0;
         waited++;
         if (waited > wait_limit)
            fail_run("the DUT never raised tx_ack");
      end
      for (int i = 1; i < body_q.size(); i++)
      begin
         if (tx_error)
            break;
         @(negedge tx_clk);
         tx_data  = body_q[i];
         tx_error = (i == err_at);
      end
      @(negedge tx_clk);
      tx_valid = 1'b0;
      tx_error = 1'b0;
      tx_data  = '0;
   endtask

   task automatic send_pause();
      @(negedge tx_clk);
      pause_req = 1'b1;
      @(negedge tx_clk);
      pause_req = 1'b0;
   endtask

   task automatic padded_frame();
      int first;
      first = frame_size.size();
      fill_payload(20);
      make_expected();
      send_payload(-1, 1'b0);
      wait_frames(first + 1);
      check_value("padded frame length", frame_size[first], 72);
      verify_frame(first);
   endtask

   task automatic long_frame();
      int first;
      int acks;
      first = frame_size.size();
      acks  = ack_total;
      fill_payload(100);
      make_expected();
      send_payload(-1, 1'b0);
      wait_frames(first + 1);
      verify_frame(first);
      check_value("tx_ack pulses in one frame", ack_total - acks, 1);
   endtask

   // error with payload byte 10 ends the frame after one er byte
   task automatic underrun_recovery();
      int first;
      first = frame_size.size();
      fill_payload(30);
      make_expected();
      send_payload(10, 1'b0);
      wait_frames(first + 1);
      check_value("underrun frame length", frame_size[first], 8 + 11 + 1);
      check_value("underrun tx_er cycles", frame_er[first], 1);
      check_value("underrun tx_er position", er_pos[first], 8 + 11);
      compare_bytes(first, 8 + 11);
      fill_payload(64);
      make_expected();
      send_payload(-1, 1'b0);
      wait_frames(first + 2);
      verify_frame(first + 1);
   endtask

   task automatic pause_only();
      int          first;
      logic [31:0] r;
      first = frame_size.size();
      r = xorshift32();
      @(negedge tx_clk);
      mac_addr   = {r[15:0], xorshift32()};
      pause_time = r[31:16];
      send_pause();
      wait_frames(first + 1);
      load_pause_body(mac_addr, pause_time);
      make_expected();
      verify_frame(first);
   endtask

   // frame a, then pause_req with frame b while a is still on the wire
   task automatic pause_priority();
      int          first;
      logic [31:0] r;
      byte_t       a_q[$];
      first = frame_size.size();
      fill_payload(40);
      make_expected();
      a_q = exp_q;
      send_payload(-1, 1'b0);
      fill_payload(50);
      r = xorshift32();
      pause_time = r[15:0];
      send_payload(-1, 1'b1);
      wait_frames(first + 3);
      make_expected();
      verify_frame(first + 2);
      exp_q = a_q;
      verify_frame(first);
      load_pause_body(mac_addr, pause_time);
      make_expected();
      verify_frame(first + 1);
      check_value("gap before pause frame", frame_gap[first + 1] >= ifg_cycles, 1);
      check_value("gap before data frame", frame_gap[first + 2] >= ifg_cycles, 1);
   endtask

   initial
   begin
      #(watchdog_ns);
      fail_run("watchdog expired before the tests finished");
   end

   // any failed assertion in the bound checker ends the run
   initial
   begin
      wait (gemac_tx_top_inst.gemac_tx_inst.gemac_tx_assert_inst.fail_count != 0);
      fail_run("a protocol assertion failed inside gemac_tx");
   end

   initial
   begin
      tx_data    = '0;
      tx_valid   = 1'b0;
      tx_error   = 1'b0;
      ifg        = 8'(ifg_cycles);
      mac_addr   = '0;
      pause_req  = 1'b0;
      pause_time = '0;
      @(negedge reset);
      check_value("gmii_tx_en after reset", gmii_tx_en, 0);
      check_value("gmii_tx_er after reset", gmii_tx_er, 0);
      check_value("gmii_txd after reset", gmii_txd, 0);
      check_value("tx_ack after reset", tx_ack, 0);
      padded_frame();
      long_frame();
      underrun_recovery();
      pause_only();
      pause_priority();
      $display("ALL TESTS PASSED");
      $finish;
   end

endmodule

// File: build.f
verilog/gemac_pkg.sv
verilog/gemac_ifs.sv
verilog/eth_crc32.sv
verilog/pause_frame_src.sv
verilog/gemac_tx.sv
verilog/gemac_tx_top.sv
verif/tb_clock.sv
verif/gemac_tx_assert.sv
verif/gemac_tx_tb.sv
